/* dv/clk_gen.sv */
//****************************************
// testbench clock
// free-running clock, 100 ns period
//****************************************

`timescale 1ns/1ps

module clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // half period
  end

endmodule

/* dv/icache_tb.sv */
//****************************************
// icache testbench
// fetch stimulus against a stalling
// memory model, checked by assertions
//****************************************

`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb;

  localparam int WAIT_LIMIT = 200;  // cycles allowed per wait
  localparam int K_ANY      = 0;    // hit or miss not known
  localparam int K_MISS     = 1;
  localparam int K_HIT      = 2;

  logic                      clk;
  logic                      rst;
  logic                      fetch_valid;
  logic                      fetch_ready;
  icache_pkg::fetch_addr_u   fetch_addr;
  logic                      line_valid;
  logic                      line_ready;
  logic [`ICACHE_LINE_W-1:0] line_data;
  logic                      mem_ar_valid;
  logic                      mem_ar_ready;
  icache_pkg::mem_ar_t       mem_ar;
  logic                      mem_r_valid;
  logic                      mem_r_ready;
  logic [`ICACHE_BEAT_W-1:0] mem_r_data;

  int                        seed;
  int                        errors;
  int                        timeouts;
  int                        ar_count;
  int                        exp_count;
  int                        expect_kind;
  string                     test_name;
  logic [`ICACHE_ADDR_W-1:0] cur_addr;  // fetch in flight
  icache_pkg::fetch_addr_u   pool [4];

  clk_gen u_clk_gen (.clk_o(clk));

  mem_model u_mem_model (
    .clk (clk), .rst (rst),
    .mem_ar_valid_i (mem_ar_valid), .mem_ar_ready_o (mem_ar_ready), .mem_ar_i (mem_ar),
    .mem_r_valid_o (mem_r_valid), .mem_r_ready_i (mem_r_ready), .mem_r_data_o (mem_r_data),
    .ar_count_o (ar_count)
  );

  icache_top u_icache_top (
    .clk (clk), .rst (rst),
    .fetch_valid_i (fetch_valid), .fetch_ready_o (fetch_ready), .fetch_addr_i (fetch_addr),
    .line_valid_o (line_valid), .line_ready_i (line_ready), .line_data_o (line_data),
    .mem_ar_valid_o (mem_ar_valid), .mem_ar_ready_i (mem_ar_ready), .mem_ar_o (mem_ar),
    .mem_r_valid_i (mem_r_valid), .mem_r_ready_o (mem_r_ready), .mem_r_data_i (mem_r_data)
  );

  // beat 0 is the line address, beat 1 its inverse
  function automatic logic [`ICACHE_LINE_W-1:0] line_rule(input logic [`ICACHE_ADDR_W-1:0] a);
    logic [`ICACHE_BEAT_W-1:0] lo;
    lo = {{(`ICACHE_BEAT_W-`ICACHE_ADDR_W){1'b0}},
          a[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    return {~lo, lo};
  endfunction

  function automatic icache_pkg::mem_ar_t req_rule(input logic [`ICACHE_ADDR_W-1:0] a);
    icache_pkg::mem_ar_t r;
    r.addr = {a[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    r.len  = 1'b1;  // two beats
    return r;
  endfunction

  a_reset_state: assert property (@(posedge clk) $fell(rst) |->
    {fetch_ready, line_valid, mem_ar_valid, mem_r_ready} == 4'b1000)
    else begin
      errors = errors + 1;
      $display("Fail %s: expected %b actual %b", test_name, 4'b1000,
               $sampled({fetch_ready, line_valid, mem_ar_valid, mem_r_ready}));
    end

  a_req_addr: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid |-> mem_ar == req_rule(cur_addr))
    else begin
      errors = errors + 1;
      $display("Fail %s: expected %h actual %h", test_name,
               req_rule($sampled(cur_addr)), $sampled(mem_ar));
    end

  a_line_data: assert property (@(posedge clk) disable iff (rst)
    line_valid |-> line_data == line_rule(cur_addr))
    else begin
      errors = errors + 1;
      $display("Fail %s: expected %h actual %h", test_name,
               line_rule($sampled(cur_addr)), $sampled(line_data));
    end

  a_req_count: assert property (@(posedge clk) disable iff (rst)
    line_valid && line_ready && expect_kind != K_ANY |-> ar_count == exp_count)
    else begin
      errors = errors + 1;
      $display("Fail %s: expected %0d actual %0d", test_name, exp_count, ar_count);
    end

  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && fetch_ready && expect_kind == K_HIT |=> line_valid)
    else begin
      errors = errors + 1;
      $display("%s: hit line did not follow acceptance by one cycle", test_name);
    end

  a_line_hold: assert property (@(posedge clk) disable iff (rst)
    line_valid && !line_ready |=> line_valid && $stable(line_data))
    else begin
      errors = errors + 1;
      $display("%s: line dropped or changed under back-pressure", test_name);
    end

  a_ready_taken: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && fetch_ready |=> !fetch_ready)
    else begin
      errors = errors + 1;
      $display("%s: fetch_ready_o high the cycle after acceptance", test_name);
    end

  // request, burst and line return all count as in flight
  a_ready_busy: assert property (@(posedge clk) disable iff (rst)
    line_valid || mem_ar_valid || mem_r_ready |-> !fetch_ready)
    else begin
      errors = errors + 1;
      $display("%s: fetch_ready_o high while a fetch is in flight", test_name);
    end

  a_r_ready: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid && mem_ar_ready |=> mem_r_ready)
    else begin
      errors = errors + 1;
      $display("%s: mem_r_ready_o not raised after the address transfer", test_name);
    end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic note_timeout(input string what);
    timeouts = timeouts + 1;
    $display("%s: timed out waiting for %s", test_name, what);
  endtask

  // one fetch with line_ready held low for hold cycles once the line shows
  task automatic fetch_line(input logic [`ICACHE_ADDR_W-1:0] a, input int kind, input int hold);
    int t;
    cur_addr       = a;
    expect_kind    = kind;
    exp_count      = ar_count + ((kind == K_MISS) ? 1 : 0);
    fetch_addr.raw = a;
    fetch_valid    = 1'b1;
    t = 0;
    while (!fetch_ready && t < WAIT_LIMIT) begin
      next_cycle();
      t++;
    end
    if (t == WAIT_LIMIT) note_timeout("fetch_ready_o");
    next_cycle();  // address taken at this edge
    fetch_valid = 1'b0;
    t = 0;
    while (!line_valid && t < WAIT_LIMIT) begin
      next_cycle();
      t++;
    end
    if (t == WAIT_LIMIT) note_timeout("line_valid_o");
    repeat (hold) next_cycle();
    line_ready = 1'b1;
    next_cycle();
    line_ready  = 1'b0;
    expect_kind = K_ANY;
  endtask

  initial begin
    logic [`ICACHE_ADDR_W-1:0] base;
    logic [`ICACHE_ADDR_W-1:0] a;
    seed           = 71;
    errors         = 0;
    timeouts       = 0;
    exp_count      = 0;
    expect_kind    = K_ANY;
    cur_addr       = '0;
    test_name      = "reset";
    rst            = 1'b1;
    fetch_valid    = 1'b0;
    fetch_addr.raw = '0;
    line_ready     = 1'b0;
    repeat (10) next_cycle();
    rst = 1'b0;
    next_cycle();

    test_name = "first_fetch";
    base = $random(seed);
    fetch_line(base, K_MISS, 0);

    test_name = "repeat_fetch";
    fetch_line(base, K_HIT, 0);
    fetch_line(base ^ 32'h8, K_HIT, 0);  // other half of the same line

    test_name = "same_index";
    for (int i = 0; i < 3; i++) begin
      fetch_line(base + 32'h10 + i * 32'h400, K_MISS, 0);  // next set with a new tag each
    end
    fetch_line(base + 32'h10 + 2 * 32'h400, K_HIT, 0);

    test_name = "back_pressure";
    for (int i = 0; i < 6; i++) begin
      a = $random(seed);
      fetch_line(a, K_ANY, ($random(seed) & 7) + 1);
      fetch_line(a, K_HIT, ($random(seed) & 7) + 1);
    end

    test_name = "random_pool";
    for (int i = 0; i < 4; i++) begin
      pool[i].raw = $random(seed);
      pool[i].f.index = pool[0].f.index;  // four lines fight over two ways
    end
    for (int n = 0; n < 40; n++) begin
      fetch_line(pool[$random(seed) & 3].raw, K_ANY, $random(seed) & 3);
    end

    $display("errors: %0d, timeouts: %0d, memory requests: %0d", errors, timeouts, ar_count);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* dv/mem_model.sv */
//****************************************
// memory responder
// two-beat line bursts with random
// stalls, data derived from the address
//****************************************

`timescale 1ns/1ps
`include "icache_macros.svh"

module mem_model (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mem_ar_valid_i,
  output logic                      mem_ar_ready_o,
  input  icache_pkg::mem_ar_t       mem_ar_i,
  output logic                      mem_r_valid_o,
  input  logic                      mem_r_ready_i,
  output logic [`ICACHE_BEAT_W-1:0] mem_r_data_o,
  output int                        ar_count_o
);

  int                        seed;
  int                        stall;
  logic                      busy;      // burst owed to the cache
  logic                      beat;
  logic                      ar_fire;
  logic                      r_fire;
  logic                      ar_seen;
  icache_pkg::mem_ar_t       req;
  logic [`ICACHE_BEAT_W-1:0] base_beat;

  initial begin
    seed           = 71;
    stall          = 0;
    busy           = 1'b0;
    beat           = 1'b0;
    base_beat      = '0;
    mem_ar_ready_o = 1'b0;
    mem_r_valid_o  = 1'b0;
    mem_r_data_o   = '0;
    ar_count_o     = 0;
    forever begin
      @(posedge clk);
      // handshakes judged on the values held across this edge
      ar_fire = mem_ar_valid_i && mem_ar_ready_o;
      r_fire  = mem_r_valid_o && mem_r_ready_i;
      ar_seen = mem_ar_valid_i;
      req     = mem_ar_i;
      #1;
      if (rst) begin
        mem_ar_ready_o = 1'b0;
        mem_r_valid_o  = 1'b0;
        busy           = 1'b0;
        beat           = 1'b0;
        ar_count_o     = 0;
      end else if (ar_fire) begin
        ar_count_o     = ar_count_o + 1;
        base_beat      = {{(`ICACHE_BEAT_W-`ICACHE_ADDR_W){1'b0}}, req.addr};
        mem_ar_ready_o = 1'b0;
        busy           = 1'b1;
        beat           = 1'b0;
        stall          = $random(seed) & 3;
      end else if (!busy) begin
        if (ar_seen && stall == 0) begin
          mem_ar_ready_o = 1'b1;
        end else if (ar_seen) begin
          stall = stall - 1;
        end
      end else if (r_fire) begin
        mem_r_valid_o = 1'b0;
        stall         = $random(seed) & 3;
        if (beat) begin
          busy = 1'b0;  // second beat taken
        end
        beat = ~beat;
      end else if (!mem_r_valid_o) begin
        if (stall == 0) begin
          mem_r_valid_o = 1'b1;
          mem_r_data_o  = beat ? ~base_beat : base_beat;
        end else begin
          stall = stall - 1;
        end
      end
    end
  end

endmodule

/* logic/icache_ctrl.sv */
//****************************************
// icache controller
// lookup, miss request, two-beat fill
// and line return with back-pressure
//****************************************

`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  icache_pkg::fetch_addr_u    fetch_addr_i,
  output logic                       line_valid_o,
  input  logic                       line_ready_i,
  output logic [`ICACHE_LINE_W-1:0]  line_data_o,
  output logic                       mem_ar_valid_o,
  input  logic                       mem_ar_ready_i,
  output icache_pkg::mem_ar_t        mem_ar_o,
  input  logic                       mem_r_valid_i,
  output logic                       mem_r_ready_o,
  input  logic [`ICACHE_BEAT_W-1:0]  mem_r_data_i,
  output logic [`ICACHE_INDEX_W-1:0] lookup_index_o,
  output logic [`ICACHE_TAG_W-1:0]   lookup_tag_o,
  input  logic                       hit_i,
  input  logic                       hit_way_i,
  input  logic                       victim_way_i,
  input  logic                       beat_i,
  output logic                       beat_step_o,
  output logic                       burst_start_o,
  output icache_pkg::tag_wr_t        tag_wr_o,
  output logic                       tag_wr_en_o,
  output icache_pkg::fill_wr_t       fill_wr_o,
  output logic                       fill_wr_en_o,
  output logic [`ICACHE_INDEX_W-1:0] rd_index_o,
  output logic                       rd_way_o,
  input  logic [`ICACHE_LINE_W-1:0]  rd_data_i
);

  typedef enum logic [2:0] {ST_IDLE, ST_HIT, ST_AR, ST_R, ST_HOLD} state_e;

  state_e                  state_q;
  state_e                  state_d;
  icache_pkg::fetch_addr_u addr_q;      // accepted fetch address
  logic                    way_q;       // hit way or chosen victim
  logic                    ar_valid_q;
  logic [`ICACHE_LINE_W/`ICACHE_BEAT_W-1:0][`ICACHE_BEAT_W-1:0] line_q;

  logic accept;
  logic miss;
  logic ar_fire;
  logic r_fire;
  logic last_beat;

  assign accept    = fetch_valid_i && fetch_ready_o;
  assign miss      = accept && !hit_i;
  assign ar_fire   = mem_ar_valid_o && mem_ar_ready_i;
  assign r_fire    = mem_r_valid_i && mem_r_ready_o;
  assign last_beat = r_fire && beat_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept) state_d = hit_i ? ST_HIT : ST_AR;
      ST_HIT:  if (line_ready_i) state_d = ST_IDLE;
      ST_AR:   if (ar_fire) state_d = ST_R;
      ST_R:    if (last_beat) state_d = ST_HOLD;
      ST_HOLD: if (line_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      ar_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (miss) begin
        ar_valid_q <= 1'b1;
      end else if (ar_fire) begin
        ar_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q.raw <= fetch_addr_i.raw;
      way_q      <= hit_i ? hit_way_i : victim_way_i;
    end
    if (r_fire) begin
      line_q[beat_i] <= mem_r_data_i;  // assemble line for HOLD
    end
  end

  // fetch side
  assign fetch_ready_o = (state_q == ST_IDLE);
  assign line_valid_o  = (state_q == ST_HIT) || (state_q == ST_HOLD);
  assign line_data_o   = (state_q == ST_HIT) ? rd_data_i : line_q;

  // memory side
  assign mem_ar_valid_o = ar_valid_q;
  assign mem_ar_o.addr  = {addr_q.raw[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                           {`ICACHE_OFFSET_W{1'b0}}};
  assign mem_ar_o.len   = 1'b1;
  assign mem_r_ready_o  = (state_q == ST_R);

  // lookup always follows the incoming address
  assign lookup_index_o = fetch_addr_i.f.index;
  assign lookup_tag_o   = fetch_addr_i.f.tag;

  assign burst_start_o = miss;
  assign beat_step_o   = r_fire && !beat_i;

  // new tag goes in invalid on miss, valid after the last beat
  assign tag_wr_en_o = miss || last_beat;
  always_comb begin
    if (state_q == ST_IDLE) begin
      tag_wr_o.way   = victim_way_i;
      tag_wr_o.index = fetch_addr_i.f.index;
      tag_wr_o.tag   = fetch_addr_i.f.tag;
      tag_wr_o.valid = 1'b0;
    end else begin
      tag_wr_o.way   = way_q;
      tag_wr_o.index = addr_q.f.index;
      tag_wr_o.tag   = addr_q.f.tag;
      tag_wr_o.valid = 1'b1;
    end
  end

  assign fill_wr_en_o    = r_fire;
  assign fill_wr_o.way   = way_q;
  assign fill_wr_o.index = addr_q.f.index;
  assign fill_wr_o.half  = beat_i;
  assign fill_wr_o.data  = mem_r_data_i;

  // read the hit line during IDLE, keep it steady while in HIT
  assign rd_index_o = (state_q == ST_IDLE) ? fetch_addr_i.f.index : addr_q.f.index;
  assign rd_way_o   = (state_q == ST_IDLE) ? hit_way_i : way_q;

  a_ar_only_in_ar: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o |-> (state_q == ST_AR))
    else $error("mem_ar_valid_o high outside AR");

  a_line_hold: assert property (@(posedge clk) disable iff (rst)
    line_valid_o && !line_ready_i |=> line_valid_o && $stable(line_data_o))
    else $error("line dropped or changed before transfer");

endmodule

/* logic/icache_data_array.sv */
//****************************************
// icache data array
// two ways of 64 lines, half-line
// writes and a registered line read
//****************************************

`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_data_array (
  input  logic                       clk,
  input  icache_pkg::fill_wr_t       fill_wr_i,
  input  logic                       fill_wr_en_i,
  input  logic [`ICACHE_INDEX_W-1:0] rd_index_i,
  input  logic                       rd_way_i,
  output logic [`ICACHE_LINE_W-1:0]  rd_data_o
);

  localparam int unsigned SETS   = 1 << `ICACHE_INDEX_W;
  localparam int unsigned HALVES = `ICACHE_LINE_W / `ICACHE_BEAT_W;

  // each line kept as two beat-wide halves
  logic [HALVES-1:0][`ICACHE_BEAT_W-1:0] line_mem [`ICACHE_WAYS][SETS];

  always_ff @(posedge clk) begin
    if (fill_wr_en_i) begin
      line_mem[fill_wr_i.way][fill_wr_i.index][fill_wr_i.half] <= fill_wr_i.data;
    end
  end

  // read data lands one cycle after the index
  always_ff @(posedge clk) begin
    rd_data_o <= line_mem[rd_way_i][rd_index_i];
  end

endmodule

/* logic/icache_fill_cnt.sv */
//****************************************
// icache fill counter
// burst beat number and free-running
// victim way pointer
//****************************************

`timescale 1ns/1ps

module icache_fill_cnt (
  input  logic clk,
  input  logic rst,
  input  logic burst_start_i,
  input  logic beat_step_i,
  output logic beat_o,
  output logic victim_way_o
);

  logic beat_q;    // 0 = low half, 1 = last beat
  logic victim_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q   <= 1'b0;
      victim_q <= 1'b0;
    end else begin
      victim_q <= ~victim_q;  // flips every cycle over two ways
      if (burst_start_i) begin
        beat_q <= 1'b0;
      end else if (beat_step_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  assign beat_o       = beat_q;
  assign victim_way_o = victim_q;

  // a burst never steps past its second beat
  a_no_step_past_last: assert property (@(posedge clk) disable iff (rst)
    beat_step_i |-> !beat_q)
    else $error("beat step on last beat");

endmodule

/* logic/icache_macros.svh */
//****************************************
// icache geometry
// address split, way count and the
// memory beat and line widths
//****************************************

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address split as tag | index | offset
`define ICACHE_ADDR_W    32
`define ICACHE_TAG_W     22
`define ICACHE_INDEX_W   6   // 64 sets
`define ICACHE_OFFSET_W  4   // 16 byte lines

// organisation
`define ICACHE_WAYS      2

// memory beat and full line
`define ICACHE_BEAT_W    64
`define ICACHE_LINE_W    128 // two beats per line

`endif

/* logic/icache_pkg.sv */
//****************************************
// icache types
// fetch address views and the records
// passed between the cache blocks
//****************************************

`include "icache_macros.svh"

package icache_pkg;

  // field view of a fetch address
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } fetch_fields_t;

  // same word, raw or split
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    fetch_fields_t             f;
  } fetch_addr_u;

  // memory read request
  typedef struct packed {
    logic [`ICACHE_ADDR_W-1:0] addr;  // line aligned
    logic                      len;   // 1 = two beats
  } mem_ar_t;

  // tag array update
  typedef struct packed {
    logic                       way;
    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic                       valid;
  } tag_wr_t;

  // half-line write into the data array
  typedef struct packed {
    logic                       way;
    logic [`ICACHE_INDEX_W-1:0] index;
    logic                       half;  // 0 = low 64 bits
    logic [`ICACHE_BEAT_W-1:0]  data;
  } fill_wr_t;

endpackage

/* logic/icache_tag_array.sv */
//****************************************
// icache tag array
// tag and valid per way and set,
// parallel compare and hit way encode
//****************************************

`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tag_array (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`ICACHE_INDEX_W-1:0] lookup_index_i,
  input  logic [`ICACHE_TAG_W-1:0]   lookup_tag_i,
  output logic                       hit_o,
  output logic                       hit_way_o,
  input  icache_pkg::tag_wr_t        tag_wr_i,
  input  logic                       tag_wr_en_i
);

  localparam int unsigned SETS = 1 << `ICACHE_INDEX_W;

  logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][SETS];
  logic [SETS-1:0]          valid_q [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0]  hit_vec;

  // valid bits all cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else if (tag_wr_en_i) begin
      valid_q[tag_wr_i.way][tag_wr_i.index] <= tag_wr_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr_en_i) begin
      tag_mem[tag_wr_i.way][tag_wr_i.index] <= tag_wr_i.tag;
    end
  end

  // compare every way at once
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_vec[w] = valid_q[w][lookup_index_i] &&
                   (tag_mem[w][lookup_index_i] == lookup_tag_i);
    end
  end

  always_comb begin
    hit_way_o = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_way_o = w[0];
      end
    end
  end

  assign hit_o = |hit_vec;

  // a line is only ever resident in one way
  a_single_hit: assert property (@(posedge clk) disable iff (rst)
    $onehot0(hit_vec))
    else $error("tag hit in more than one way");

endmodule

/* logic/icache_top.sv */
//****************************************
// icache top
// two-way read-only instruction cache
// fetch side and memory burst side
//****************************************

`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_valid_i,
  output logic                      fetch_ready_o,
  input  icache_pkg::fetch_addr_u   fetch_addr_i,
  output logic                      line_valid_o,
  input  logic                      line_ready_i,
  output logic [`ICACHE_LINE_W-1:0] line_data_o,
  output logic                      mem_ar_valid_o,
  input  logic                      mem_ar_ready_i,
  output icache_pkg::mem_ar_t       mem_ar_o,
  input  logic                      mem_r_valid_i,
  output logic                      mem_r_ready_o,
  input  logic [`ICACHE_BEAT_W-1:0] mem_r_data_i
);

  // lookup path
  logic [`ICACHE_INDEX_W-1:0] lookup_index;
  logic [`ICACHE_TAG_W-1:0]   lookup_tag;
  logic                       hit;
  logic                       hit_way;

  // fill counter
  logic victim_way;
  logic beat;
  logic beat_step;
  logic burst_start;

  // array writes and read
  icache_pkg::tag_wr_t        tag_wr;
  logic                       tag_wr_en;
  icache_pkg::fill_wr_t       fill_wr;
  logic                       fill_wr_en;
  logic [`ICACHE_INDEX_W-1:0] rd_index;
  logic                       rd_way;
  logic [`ICACHE_LINE_W-1:0]  rd_data;

  icache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_addr_i   (fetch_addr_i),
    .line_valid_o   (line_valid_o),
    .line_ready_i   (line_ready_i),
    .line_data_o    (line_data_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_o       (mem_ar_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .beat_i         (beat),
    .beat_step_o    (beat_step),
    .burst_start_o  (burst_start),
    .tag_wr_o       (tag_wr),
    .tag_wr_en_o    (tag_wr_en),
    .fill_wr_o      (fill_wr),
    .fill_wr_en_o   (fill_wr_en),
    .rd_index_o     (rd_index),
    .rd_way_o       (rd_way),
    .rd_data_i      (rd_data)
  );

  icache_fill_cnt u_fill_cnt (
    .clk           (clk),
    .rst           (rst),
    .burst_start_i (burst_start),
    .beat_step_i   (beat_step),
    .beat_o        (beat),
    .victim_way_o  (victim_way)
  );

  icache_tag_array u_tag_array (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .tag_wr_i       (tag_wr),
    .tag_wr_en_i    (tag_wr_en)
  );

  icache_data_array u_data_array (
    .clk          (clk),
    .fill_wr_i    (fill_wr),
    .fill_wr_en_i (fill_wr_en),
    .rd_index_i   (rd_index),
    .rd_way_i     (rd_way),
    .rd_data_o    (rd_data)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module icache_tb -f verilog.f \
    && ./obj_dir/Vicache_tb; } > sim.log 2>&1 \
  || echo "Regression failed" >> sim.log
cat sim.log
if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

/* verilog.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_fill_cnt.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_ctrl.sv
logic/icache_top.sv
dv/clk_gen.sv
dv/mem_model.sv
dv/icache_tb.sv
